// ==== filelist.f ====
cpu_pkg.sv
sequencer.sv
program_counter.sv
execute_unit.sv
bank_port.sv
cpu_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import cpu_pkg::*;

	localparam int          SLOTS = 150;
	localparam logic [15:0] CODE_BASE = 16'h4000;
	localparam logic [15:0] STACK_BASE = 16'h8000;

	logic        clk;
	logic        reset;
	logic [14:0] even_read_addr;
	logic [14:0] odd_read_addr;
	logic [7:0]  even_read_data;
	logic [7:0]  odd_read_data;
	bank_write_t even_write;
	bank_write_t odd_write;
	logic        trap;
	logic        done;
	int          error_count;

	logic [7:0]  even_mem [0:32767];
	logic [7:0]  odd_mem [0:32767];
	logic [15:0] lfsr;

	tb_clock u_clock
	(
		.clk (clk)
	);

	cpu_top #(.RESET_PC(CODE_BASE), .RESET_SP(STACK_BASE)) i_dut
	(
		.clk            (clk),
		.reset          (reset),
		.even_read_addr (even_read_addr),
		.odd_read_addr  (odd_read_addr),
		.even_read_data (even_read_data),
		.odd_read_data  (odd_read_data),
		.even_write     (even_write),
		.odd_write      (odd_write),
		.trap           (trap)
	);

	tb_checker #(.RESET_PC(CODE_BASE), .RESET_SP(STACK_BASE), .SLOTS(SLOTS)) u_checker
	(
		.clk         (clk),
		.reset       (reset),
		.even_write  (even_write),
		.odd_write   (odd_write),
		.trap        (trap),
		.done        (done),
		.error_count (error_count)
	);

	assign even_read_data = even_mem[even_read_addr];
	assign odd_read_data = odd_mem[odd_read_addr];

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic random_bits(input int count, output logic [15:0] value);
		int i;
		value = '0;
		for (i = 0; i < count; i++)
		begin
			lfsr = lfsr_next(lfsr);
			value = {value[14:0], lfsr[0]};
		end
	endtask

	task automatic put_byte(input logic [15:0] addr, input logic [7:0] data);
		if (addr[0])
			odd_mem[addr[15:1]] = data;
		else
			even_mem[addr[15:1]] = data;
		u_checker.load_byte(addr, data);
	endtask

	// Weighted towards loads and pushes
	function automatic logic [7:0] pick_opcode(input logic [4:0] sel);
		case (sel)
			5'd0:                    return NOP;
			5'd1:                    return 8'h5c; // Unassigned byte
			5'd2, 5'd29:             return LDW_X_IMMD;
			5'd3, 5'd30:             return LDW_Y_IMMD;
			5'd4, 5'd31:             return LDW_Z_IMMD;
			5'd5, 5'd6, 5'd7, 5'd8:  return LDW_SP_IMMD;
			5'd9, 5'd10:             return PUSH_X;
			5'd11, 5'd12:            return PUSH_Y;
			5'd13, 5'd14:            return PUSH_Z;
			5'd15, 5'd16:            return PUSH_IMMD;
			5'd17, 5'd18:            return JP_IMMD;
			5'd19, 5'd20:            return JR_D;
			5'd21, 5'd22:            return JRZ_D;
			5'd23, 5'd24:            return JRNZ_D;
			5'd25, 5'd26:            return JRN_D;
			default:                 return JRNN_D;
		endcase
	endfunction

	task automatic write_slot(input int slot);
		logic [15:0] base;
		logic [15:0] r;
		logic [15:0] imm;
		logic [7:0]  op;
		int          target;
		base = CODE_BASE + 16'(4 * slot);
		random_bits(5, r);
		op = pick_opcode(r[4:0]);
		imm = {NOP, NOP};
		case (op)
			LDW_SP_IMMD:
			begin
				random_bits(15, r);
				imm = 16'ha000 + (r % 16'h5001);
			end
			LDW_X_IMMD, LDW_Y_IMMD, LDW_Z_IMMD:
			begin
				random_bits(2, r);
				if (r[1:0] == 2'd0)
					imm = 16'd0; // Gives JRZ a chance
				else
					random_bits(16, imm);
			end
			PUSH_IMMD:
				random_bits(16, imm);
			JP_IMMD:
			begin
				random_bits(3, r);
				target = slot + 1 + int'(r[2:0]);
				if (target > SLOTS)
					target = SLOTS;
				imm = CODE_BASE + 16'(4 * target);
			end
			JR_D, JRZ_D, JRNZ_D, JRN_D, JRNN_D:
			begin
				random_bits(2, r);
				target = slot + 1 + int'(r[1:0]);
				if (target > SLOTS)
					target = SLOTS;
				imm[7:0] = 8'(4 * (target - slot) - 2); // From pc + 2
			end
			default:
				;
		endcase
		put_byte(base, op);
		put_byte(base + 16'd1, imm[7:0]);
		put_byte(base + 16'd2, imm[15:8]);
		put_byte(base + 16'd3, NOP);
	endtask

	// Memory load, then bank writes from the DUT
	initial
	begin
		int a;
		int slot;
		lfsr = 16'd22;
		for (a = 0; a < 65536; a++)
		begin
			if (a < 32'h4000)
				put_byte(16'(a), 8'(a) ^ 8'(a >> 8) ^ 8'h5a);
			else
				put_byte(16'(a), TRAP);
		end
		for (slot = 0; slot < SLOTS; slot++)
			write_slot(slot);
		forever
		begin
			@(posedge clk);
			if (even_write.en)
				even_mem[even_write.addr] <= even_write.data;
			if (odd_write.en)
				odd_mem[odd_write.addr] <= odd_write.data;
		end
	end

	initial
	begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		while (!done)
			@(posedge clk);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker
#(
	parameter logic [15:0] RESET_PC = 16'h4000,
	parameter logic [15:0] RESET_SP = 16'h8000,
	parameter int          SLOTS = 150
)
(
	input  wire logic             clk,
	input  wire logic             reset,
	input  cpu_pkg::bank_write_t  even_write,
	input  cpu_pkg::bank_write_t  odd_write,
	input  wire logic             trap,
	output logic                  done,
	output int                    error_count
);
	import cpu_pkg::*;

	localparam int TIMEOUT = SLOTS * 2 + 200;

	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  data;
	} byte_write_t;

	logic [7:0]  image [0:65535];
	byte_write_t expected [$];
	int          next_write;
	int          trap_delay;   // Edges from last write to trap, -1 if no writes
	int          cycle;
	int          reset_errors;
	int          write_errors;
	int          trap_errors;
	int          odd_pushes;

	task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
		image[addr] = data;
	endtask

	// Little-endian, low byte first
	task automatic push_word(input logic [15:0] addr, input logic [15:0] data);
		expected.push_back({addr, data[7:0]});
		expected.push_back({addr + 16'd1, data[15:8]});
	endtask

	task automatic build_expected();
		logic [15:0] pc;
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] z;
		logic [15:0] sp;
		logic [15:0] imm;
		logic [15:0] target;
		logic [7:0]  op;
		logic        fn;
		logic        fz;
		logic        taken;
		logic        jump;
		logic        halted;
		int          size;
		int          steps;
		int          since_push;
		pc = RESET_PC;
		sp = RESET_SP;
		x = '0;
		y = '0;
		z = '0;
		fn = 1'b0;
		fz = 1'b0;
		halted = 1'b0;
		steps = 0;
		since_push = -1;
		while (!halted && steps < 4 * SLOTS)
		begin
			op = image[pc];
			imm = {image[pc + 16'd2], image[pc + 16'd1]};
			target = pc + 16'd2 + {{8{imm[7]}}, imm[7:0]};
			taken = 1'b0;
			jump = 1'b0;
			size = 1;
			steps++;
			case (op)
				LDW_X_IMMD, LDW_Y_IMMD, LDW_Z_IMMD, LDW_SP_IMMD:
				begin
					case (op)
						LDW_X_IMMD: x = imm;
						LDW_Y_IMMD: y = imm;
						LDW_Z_IMMD: z = imm;
						default:    sp = imm;
					endcase
					fz = (imm == 16'd0);
					fn = imm[15];
					size = 3;
				end
				PUSH_X, PUSH_Y, PUSH_Z, PUSH_IMMD:
				begin
					sp = sp - 16'd2;
					case (op)
						PUSH_X:  push_word(sp, x);
						PUSH_Y:  push_word(sp, y);
						PUSH_Z:  push_word(sp, z);
						default: push_word(sp, imm);
					endcase
					size = (op == PUSH_IMMD) ? 3 : 1;
				end
				JP_IMMD:
				begin
					jump = 1'b1;
					size = 3;
				end
				JR_D, JRZ_D, JRNZ_D, JRN_D, JRNN_D:
				begin
					case (op)
						JR_D:    taken = 1'b1;
						JRZ_D:   taken = fz;
						JRNZ_D:  taken = !fz;
						JRN_D:   taken = fn;
						default: taken = !fn;
					endcase
					size = 2;
				end
				TRAP:
					halted = 1'b1;
				default:
					;
			endcase
			if (op == PUSH_X || op == PUSH_Y || op == PUSH_Z || op == PUSH_IMMD)
				since_push = 0;
			else if (since_push >= 0)
				since_push += (size == 3) ? 2 : 1;
			pc = jump ? imm : (taken ? target : pc + 16'(size));
		end
		if (!halted)
		begin
			$display("Model ran %0d instructions without reaching a TRAP", steps);
			trap_errors++;
		end
		trap_delay = (since_push >= 0) ? since_push + 1 : -1;
	endtask

	task automatic check_idle();
		if (even_write.en !== 1'b0 || odd_write.en !== 1'b0)
		begin
			$display("A bank write enable was not low around reset at cycle %0d", cycle);
			reset_errors++;
		end
		if (trap !== 1'b0)
		begin
			$display("trap was not low around reset at cycle %0d", cycle);
			reset_errors++;
		end
	endtask

	task automatic check_byte(input string name, input logic [15:0] addr,
		input logic [7:0] data);
		if (next_write >= expected.size())
		begin
			$display("Extra byte write to %h on %s after all expected writes", addr, name);
			write_errors++;
		end
		else
		begin
			if (addr !== expected[next_write].addr)
			begin
				$display("Error: %s byte address = 0x%h, expected 0x%h", name, addr,
					expected[next_write].addr);
				write_errors++;
			end
			if (data !== expected[next_write].data)
			begin
				$display("Error: %s.data = 0x%h, expected 0x%h", name, data,
					expected[next_write].data);
				write_errors++;
			end
			next_write++;
		end
	endtask

	initial
	begin : watch
		logic [15:0] even_byte;
		logic [15:0] odd_byte;
		logic        trap_seen;
		int          since_write;
		int          hold;
		done = 1'b0;
		error_count = 0;
		reset_errors = 0;
		write_errors = 0;
		trap_errors = 0;
		odd_pushes = 0;
		next_write = 0;
		trap_seen = 1'b0;
		since_write = 0;
		hold = 0;
		@(posedge clk); // Outputs not yet reset
		cycle = 1;
		while (reset)
		begin
			@(posedge clk);
			cycle++;
			check_idle();
		end
		build_expected();
		while (hold < 4 && cycle < TIMEOUT)
		begin
			@(posedge clk);
			cycle++;
			even_byte = {even_write.addr, 1'b0};
			odd_byte = {odd_write.addr, 1'b1};
			if (even_write.en && odd_write.en && odd_byte < even_byte)
			begin
				odd_pushes++; // Low byte in the odd bank
				check_byte("odd_write", odd_byte, odd_write.data);
				check_byte("even_write", even_byte, even_write.data);
			end
			else
			begin
				if (even_write.en)
					check_byte("even_write", even_byte, even_write.data);
				if (odd_write.en)
					check_byte("odd_write", odd_byte, odd_write.data);
			end
			since_write = (even_write.en || odd_write.en) ? 0 : since_write + 1;
			if (trap_seen)
			begin
				hold++;
				if (trap !== 1'b1)
				begin
					$display("trap fell at cycle %0d after it had risen", cycle);
					trap_errors++;
				end
			end
			else if (trap === 1'b1)
			begin
				trap_seen = 1'b1;
				if (next_write < expected.size())
				begin
					$display("trap rose early, after %0d of %0d byte writes", next_write,
						expected.size());
					trap_errors++;
				end
				else if (trap_delay >= 0 && since_write != trap_delay)
				begin
					$display("trap rose %0d cycles after the last write instead of %0d",
						since_write, trap_delay);
					trap_errors++;
				end
			end
		end
		if (!trap_seen)
		begin
			$display("Timeout: trap never rose within %0d cycles", TIMEOUT);
			trap_errors++;
			if (next_write < expected.size())
			begin
				$display("%0d expected byte writes never happened", expected.size() - next_write);
				write_errors++;
			end
		end
		if (odd_pushes == 0)
		begin
			$display("No push at an odd stack address was seen");
			write_errors++;
		end
		error_count = reset_errors + write_errors + trap_errors;
		$display("Errors: reset %0d, write %0d, trap %0d, total %0d", reset_errors,
			write_errors, trap_errors, error_count);
		done = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
	output logic clk
);

	initial
		clk = 1'b0;

	always #20 clk = ~clk; // 40 ns period

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top
#(
	parameter logic [15:0] RESET_PC = 16'h4000,
	parameter logic [15:0] RESET_SP = 16'h8000
)
(
	input  wire logic             clk,
	input  wire logic             reset,
	output logic [14:0]           even_read_addr,
	output logic [14:0]           odd_read_addr,
	input  wire logic [7:0]       even_read_data,
	input  wire logic [7:0]       odd_read_data,
	output cpu_pkg::bank_write_t  even_write,
	output cpu_pkg::bank_write_t  odd_write,
	output logic                  trap
);
	import cpu_pkg::*;

	seq_state_t  state;
	logic        execute;
	opcode_t     opcode;
	logic [7:0]  disp;
	logic [15:0] read_addr;
	logic [15:0] read_word;
	logic [15:0] pc;
	flags_t      flags;
	word_write_t word_write;

	assign trap = (state == HALT);

	sequencer u_sequencer
	(
		.clk         (clk),
		.reset       (reset),
		.opcode_byte (read_word[7:0]),
		.disp_byte   (read_word[15:8]), // d8 follows the opcode
		.pc          (pc),
		.state       (state),
		.execute     (execute),
		.opcode      (opcode),
		.disp        (disp),
		.read_addr   (read_addr)
	);

	program_counter #(.RESET_PC(RESET_PC)) u_program_counter
	(
		.clk     (clk),
		.reset   (reset),
		.execute (execute),
		.opcode  (opcode),
		.disp    (disp),
		.imm     (read_word),
		.flags   (flags),
		.pc      (pc)
	);

	execute_unit #(.RESET_SP(RESET_SP)) u_execute_unit
	(
		.clk        (clk),
		.reset      (reset),
		.execute    (execute),
		.opcode     (opcode),
		.imm        (read_word),
		.flags      (flags),
		.word_write (word_write)
	);

	bank_port u_bank_port
	(
		.read_addr      (read_addr),
		.read_word      (read_word),
		.even_read_addr (even_read_addr),
		.odd_read_addr  (odd_read_addr),
		.even_read_data (even_read_data),
		.odd_read_data  (odd_read_data),
		.word_write     (word_write),
		.even_write     (even_write),
		.odd_write      (odd_write)
	);

endmodule

`default_nettype wire

// ==== bank_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_port
(
	input  wire logic [15:0]      read_addr,
	output logic [15:0]           read_word,
	output logic [14:0]           even_read_addr,
	output logic [14:0]           odd_read_addr,
	input  wire logic [7:0]       even_read_data,
	input  wire logic [7:0]       odd_read_data,
	input  cpu_pkg::word_write_t  word_write,
	output cpu_pkg::bank_write_t  even_write,
	output cpu_pkg::bank_write_t  odd_write
);
	import cpu_pkg::*;

	logic [14:0] rd_base;
	logic [14:0] wr_base;

	assign rd_base = read_addr[15:1];
	assign wr_base = word_write.addr[15:1];

	// Odd start puts the high byte in the next even location
	always_comb
	begin
		odd_read_addr = rd_base;
		if (read_addr[0])
		begin
			even_read_addr = rd_base + 15'd1;
			read_word = {even_read_data, odd_read_data};
		end
		else
		begin
			even_read_addr = rd_base;
			read_word = {odd_read_data, even_read_data};
		end
	end

	always_comb
	begin
		odd_write.addr = wr_base;
		odd_write.en = word_write.en;
		even_write.en = word_write.en;
		if (word_write.addr[0])
		begin
			even_write.addr = wr_base + 15'd1;
			even_write.data = word_write.data[15:8];
			odd_write.data = word_write.data[7:0];
		end
		else
		begin
			even_write.addr = wr_base;
			even_write.data = word_write.data[7:0];
			odd_write.data = word_write.data[15:8];
		end
	end

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit
#(
	parameter logic [15:0] RESET_SP = 16'h8000
)
(
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             execute,
	input  cpu_pkg::opcode_t      opcode,
	input  wire logic [15:0]      imm,
	output cpu_pkg::flags_t       flags,
	output cpu_pkg::word_write_t  word_write
);
	import cpu_pkg::*;

	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] z;
	logic [15:0] sp;
	logic [15:0] sp_dec;
	logic        is_push;
	flags_t      ldw_flags;

	assign sp_dec = sp - 16'd2;

	// Flags from the loaded word
	assign ldw_flags.n = imm[15];
	assign ldw_flags.z = (imm == 16'd0);

	assign is_push = (opcode == PUSH_X) || (opcode == PUSH_Y) ||
		(opcode == PUSH_Z) || (opcode == PUSH_IMMD);

	always_comb
	begin
		word_write.addr = sp_dec; // Pre-decrement
		word_write.en = execute && is_push;
		case (opcode)
			PUSH_X:  word_write.data = x;
			PUSH_Y:  word_write.data = y;
			PUSH_Z:  word_write.data = z;
			default: word_write.data = imm;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			x <= 16'd0;
			y <= 16'd0;
			z <= 16'd0;
			sp <= RESET_SP;
			flags <= '0;
		end
		else if (execute)
		begin
			case (opcode)
				LDW_X_IMMD:
				begin
					x <= imm;
					flags <= ldw_flags;
				end
				LDW_Y_IMMD:
				begin
					y <= imm;
					flags <= ldw_flags;
				end
				LDW_Z_IMMD:
				begin
					z <= imm;
					flags <= ldw_flags;
				end
				LDW_SP_IMMD:
				begin
					sp <= imm;
					flags <= ldw_flags;
				end
				PUSH_X, PUSH_Y, PUSH_Z, PUSH_IMMD:
					sp <= sp_dec;
				default:
					; // Branches, NOP and TRAP touch no register here
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter
#(
	parameter logic [15:0] RESET_PC = 16'h4000
)
(
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             execute,
	input  cpu_pkg::opcode_t      opcode,
	input  wire logic [7:0]       disp,
	input  wire logic [15:0]      imm,
	input  cpu_pkg::flags_t       flags,
	output logic [15:0]           pc
);
	import cpu_pkg::*;

	logic [15:0] pc_seq;
	logic [15:0] pc_branch;
	logic [15:0] pc_next;

	assign pc_seq = pc + {14'd0, opcode_size(opcode)};
	assign pc_branch = pc + 16'd2 + {{8{disp[7]}}, disp};

	always_comb
	begin
		case (opcode)
			JP_IMMD: pc_next = imm;
			JR_D:    pc_next = pc_branch;
			JRZ_D:   pc_next = flags.z ? pc_branch : pc_seq;
			JRNZ_D:  pc_next = flags.z ? pc_seq : pc_branch;
			JRN_D:   pc_next = flags.n ? pc_branch : pc_seq;
			JRNN_D:  pc_next = flags.n ? pc_seq : pc_branch;
			default: pc_next = pc_seq;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= RESET_PC;
		else if (execute)
			pc <= pc_next;
	end

endmodule

`default_nettype wire

// ==== sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sequencer
(
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic [7:0]         opcode_byte,
	input  wire logic [7:0]         disp_byte,
	input  wire logic [15:0]        pc,
	output cpu_pkg::seq_state_t     state,
	output logic                    execute,
	output cpu_pkg::opcode_t        opcode,
	output logic [7:0]              disp,
	output logic [15:0]             read_addr
);
	import cpu_pkg::*;

	opcode_t    live_opcode;
	opcode_t    opcode_q;
	logic [7:0] disp_q;
	logic [1:0] live_size;
	logic       running;   // Low for the first cycle out of reset
	seq_state_t state_next;

	assign live_opcode = opcode_t'(opcode_byte);
	assign live_size = opcode_size(live_opcode);

	always_comb
	begin
		state_next = state;
		case (state)
			FETCH:
			begin
				opcode = live_opcode;
				disp = disp_byte;
				read_addr = pc;
				execute = running && (live_size != 2'd3);
				if (running)
				begin
					if (live_opcode == TRAP)
						state_next = HALT;
					else if (live_size == 2'd3)
						state_next = OPERAND; // Immediate word still to come
				end
			end
			OPERAND:
			begin
				opcode = opcode_q;
				disp = disp_q;
				read_addr = pc + 16'd1;
				execute = 1'b1;
				state_next = FETCH;
			end
			default:
			begin
				opcode = NOP;
				disp = disp_q;
				read_addr = pc;
				execute = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= FETCH;
			running <= 1'b0;
		end
		else
		begin
			state <= state_next;
			running <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == FETCH)
		begin
			opcode_q <= live_opcode;
			disp_q <= disp_byte;
		end
	end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef enum logic [7:0]
	{
		NOP         = 8'h00,
		LDW_X_IMMD  = 8'h10,
		LDW_Y_IMMD  = 8'h11,
		LDW_Z_IMMD  = 8'h12,
		LDW_SP_IMMD = 8'h13,
		PUSH_X      = 8'h20,
		PUSH_Y      = 8'h21,
		PUSH_Z      = 8'h22,
		PUSH_IMMD   = 8'h23,
		JP_IMMD     = 8'h30,
		JR_D        = 8'h40,
		JRZ_D       = 8'h41,
		JRNZ_D      = 8'h42,
		JRN_D       = 8'h43,
		JRNN_D      = 8'h44,
		TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [1:0]
	{
		FETCH,
		OPERAND,
		HALT
	} seq_state_t;

	typedef struct packed
	{
		logic n;
		logic z;
	} flags_t;

	// Little-endian word write at any byte address
	typedef struct packed
	{
		logic [15:0] addr;
		logic [15:0] data;
		logic        en;
	} word_write_t;

	typedef struct packed
	{
		logic [14:0] addr;
		logic [7:0]  data;
		logic        en;
	} bank_write_t;

	// Unknown bytes run as one-byte NOPs
	function automatic logic [1:0] opcode_size(input opcode_t op);
		case (op)
			LDW_X_IMMD, LDW_Y_IMMD, LDW_Z_IMMD, LDW_SP_IMMD,
			PUSH_IMMD, JP_IMMD:                 return 2'd3;
			JR_D, JRZ_D, JRNZ_D, JRN_D, JRNN_D: return 2'd2;
			default:                            return 2'd1;
		endcase
	endfunction

endpackage

`default_nettype wire
